//--- rtl/aes_field_pkg.sv
/*
 * AES field arithmetic definitions
 * byte type, reduction polynomial and affine constant for GF(2^8)
 */
`default_nettype none

package aes_field_pkg;

	// one state byte or field element
	typedef logic [7:0] gf_byte_t;

	// low byte of x^8 + x^4 + x^3 + x + 1
	localparam gf_byte_t gf_poly = 8'h1b;

	// constant added after the affine matrix in the s-box
	localparam gf_byte_t sbox_affine_const = 8'h63;

	////////////////////////////////////////////////////////////////////////////
	// multiply by x
	////////////////////////////////////////////////////////////////////////////

	// shift left and fold the carry back with the polynomial
	function automatic gf_byte_t xtime(input gf_byte_t b);
		gf_byte_t shifted;
		shifted = {b[6:0], 1'b0};
		if (b[7])
			shifted = shifted ^ gf_poly;
		return shifted;
	endfunction

endpackage

`default_nettype wire

//--- rtl/aes_cipher_pkg.sv
/*
 * AES-128 cipher framing definitions
 * block, word and round types, round constants and controller states
 */
`default_nettype none

package aes_cipher_pkg;

	// 128-bit block, column-major with byte 0 in [127:120]
	//   [127:96] w0   [95:64] w1   [63:32] w2   [31:0] w3
	typedef logic [127:0] aes_block_t;

	// one 32-bit column, top byte in [31:24]
	typedef logic [31:0] aes_word_t;

	// round index 0 to 10
	typedef logic [3:0] aes_round_t;

	// Nr for a 128-bit key
	localparam aes_round_t aes_nr = 4'd10;

	// one cycle for SubBytes capture, one for the commit
	localparam int aes_round_cycles = 2;

	// load edge to done edge
	localparam int aes_latency = aes_round_cycles * aes_nr;

	////////////////////////////////////////////////////////////////////////////
	// key schedule round constants
	////////////////////////////////////////////////////////////////////////////

	// indexed by round minus one, only the top byte is nonzero
	localparam aes_word_t rcon_table [0:9] = '{
		32'h01000000,
		32'h02000000,
		32'h04000000,
		32'h08000000,
		32'h10000000,
		32'h20000000,
		32'h40000000,
		32'h80000000,
		32'h1b000000,
		32'h36000000
	};

	// round sequencer phases
	typedef enum logic [1:0] {
		ctrl_idle = 2'd0,
		ctrl_sub  = 2'd1,
		ctrl_mix  = 2'd2
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/sbox.sv
/*
 * AES s-box
 * multiplicative inverse in GF(2^8) followed by the affine transform
 */
`timescale 1ns/1ps
`default_nettype none

module sbox import aes_field_pkg::*; (
	input  gf_byte_t a,
	output gf_byte_t y
);

	// shift-and-add multiply, reduced on every step
	function automatic gf_byte_t gf_mul(input gf_byte_t x, input gf_byte_t z);
		gf_byte_t acc;
		gf_byte_t sh;
		acc = '0;
		sh = x;
		for (int i = 0; i < 8; i++) begin
			if (z[i])
				acc = acc ^ sh;
			sh = xtime(sh);
		end
		return acc;
	endfunction

	function automatic gf_byte_t gf_sq(input gf_byte_t x);
		return gf_mul(x, x);
	endfunction

	// powers of a on the way to a^254
	gf_byte_t p2, p3, p6, p7, p14, p15, p30, p31;
	gf_byte_t p62, p63, p126, p127;
	gf_byte_t inv;

	////////////////////////////////////////////////////////////////////////////
	// inverse as a^254, so zero maps to zero
	////////////////////////////////////////////////////////////////////////////

	assign p2   = gf_sq(a);
	assign p3   = gf_mul(p2, a);
	assign p6   = gf_sq(p3);
	assign p7   = gf_mul(p6, a);
	assign p14  = gf_sq(p7);
	assign p15  = gf_mul(p14, a);
	assign p30  = gf_sq(p15);
	assign p31  = gf_mul(p30, a);
	assign p62  = gf_sq(p31);
	assign p63  = gf_mul(p62, a);
	assign p126 = gf_sq(p63);
	assign p127 = gf_mul(p126, a);
	assign inv  = gf_sq(p127);

	// affine step as b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
	assign y = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
		{inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ sbox_affine_const;

endmodule

`default_nettype wire

//--- rtl/mix_columns.sv
/*
 * AES MixColumns over all four columns
 * lightweight form with one xtime per output byte
 */
`timescale 1ns/1ps
`default_nettype none

module mix_columns import aes_field_pkg::*, aes_cipher_pkg::*; (
	input  aes_block_t state_in,
	output aes_block_t state_out
);

	// column c sits in word c, byte r of a column in [31-8r -: 8]
	always_comb begin
		aes_word_t col;
		gf_byte_t  b [0:3];
		gf_byte_t  all_xor;
		for (int c = 0; c < 4; c++) begin
			col = state_in[127 - 32*c -: 32];
			for (int r = 0; r < 4; r++)
				b[r] = col[31 - 8*r -: 8];
			// shared term of every output byte in the column
			all_xor = b[0] ^ b[1] ^ b[2] ^ b[3];
			// byte r also sees 2*(b[r] ^ b[r+1]), wrapping at the bottom
			for (int r = 0; r < 4; r++)
				state_out[127 - 32*c - 8*r -: 8] =
					b[r] ^ all_xor ^ xtime(b[r] ^ b[(r + 1) % 4]);
		end
	end

endmodule

`default_nettype wire

//--- rtl/round_datapath.sv
/*
 * AES cipher round datapath
 * state register, registered SubBytes, ShiftRows, MixColumns and AddRoundKey
 */
`timescale 1ns/1ps
`default_nettype none

module round_datapath import aes_cipher_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       load,
	input  aes_block_t plaintext,
	input  aes_block_t key,
	input  aes_block_t next_round_key,
	input  logic       commit,
	input  logic       final_round,
	output aes_block_t state
);

	aes_block_t sub_bytes;
	aes_block_t sub_q;
	aes_block_t shifted;
	aes_block_t mixed;
	aes_block_t round_out;

	////////////////////////////////////////////////////////////////////////////
	// SubBytes, one s-box per state byte
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 16; i++) begin : g_sub
		sbox i_sbox (
			.a (state[127 - 8*i -: 8]),
			.y (sub_bytes[127 - 8*i -: 8])
		);
	end

	// free-running capture
	// valid in the mix phase since state only moves at commit
	always_ff @(posedge clk) begin
		sub_q <= sub_bytes;
	end

	////////////////////////////////////////////////////////////////////////////
	// ShiftRows on the registered bytes
	////////////////////////////////////////////////////////////////////////////

	// byte 4c+r of the output comes from column (c+r) mod 4 of the same row
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				shifted[127 - 8*(4*c + r) -: 8] =
					sub_q[127 - 8*(4*((c + r) % 4) + r) -: 8];
		end
	end

	mix_columns i_mix_columns (
		.state_in  (shifted),
		.state_out (mixed)
	);

	// round 10 skips MixColumns
	assign round_out = (final_round ? shifted : mixed) ^ next_round_key;

	////////////////////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////////////////////

	// load does the initial AddRoundKey with the cipher key
	// and wins over a commit of an abandoned run
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= '0;
		end else if (load) begin
			state <= plaintext ^ key;
		end else if (commit) begin
			state <= round_out;
		end
	end

endmodule

`default_nettype wire

//--- rtl/key_expander.sv
/*
 * AES-128 key schedule
 * round-key register with RotWord, registered SubWord, Rcon and word chaining
 */
`timescale 1ns/1ps
`default_nettype none

module key_expander import aes_cipher_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       load,
	input  aes_block_t key,
	input  aes_round_t round,
	input  logic       commit,
	output aes_block_t next_round_key
);

	aes_block_t round_key;
	aes_word_t  rot_word;
	aes_word_t  sub_word;
	aes_word_t  sub_word_q;
	aes_round_t rcon_sel;
	aes_word_t  rcon_word;
	aes_word_t  w0, w1, w2, w3;

	// RotWord of the last word, one byte to the left
	assign rot_word = {round_key[23:0], round_key[31:24]};

	for (genvar i = 0; i < 4; i++) begin : g_sub_word
		sbox i_sbox (
			.a (rot_word[31 - 8*i -: 8]),
			.y (sub_word[31 - 8*i -: 8])
		);
	end

	// captures every cycle, settled by the mix phase
	always_ff @(posedge clk) begin
		sub_word_q <= sub_word;
	end

	////////////////////////////////////////////////////////////////////////////
	// next round key
	////////////////////////////////////////////////////////////////////////////

	// rounds run 1 to 10, anything else picks no constant
	assign rcon_sel  = round - 4'd1;
	assign rcon_word = (rcon_sel < aes_nr) ? rcon_table[rcon_sel] : '0;

	// first word takes SubWord and Rcon, the rest chain off the previous word
	assign w0 = round_key[127:96] ^ sub_word_q ^ rcon_word;
	assign w1 = round_key[95:64] ^ w0;
	assign w2 = round_key[63:32] ^ w1;
	assign w3 = round_key[31:0] ^ w2;

	assign next_round_key = {w0, w1, w2, w3};

	// round key moves on the same edge as the cipher state
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			round_key <= '0;
		end else if (load) begin
			round_key <= key;
		end else if (commit) begin
			round_key <= next_round_key;
		end
	end

endmodule

`default_nettype wire

//--- rtl/round_controller.sv
/*
 * AES round sequencer
 * two phases per round, round counter and the done level
 */
`timescale 1ns/1ps
`default_nettype none

module round_controller import aes_cipher_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       load,
	output aes_round_t round,
	output logic       commit,
	output logic       final_round,
	output logic       done
);

	ctrl_state_t phase;
	ctrl_state_t phase_next;
	aes_round_t  round_next;
	logic        done_next;

	// registers update in the second phase of every round
	assign commit      = (phase == ctrl_mix);
	assign final_round = (round == aes_nr);

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		phase_next = phase;
		round_next = round;
		done_next  = done;
		if (load) begin
			// restart from round 1 whatever is running
			phase_next = ctrl_sub;
			round_next = 4'd1;
			done_next  = 1'b0;
		end else begin
			case (phase)
				ctrl_sub: begin
					phase_next = ctrl_mix;
				end
				ctrl_mix: begin
					if (final_round) begin
						// tenth commit ends the run
						phase_next = ctrl_idle;
						done_next  = 1'b1;
					end else begin
						phase_next = ctrl_sub;
						round_next = round + 4'd1;
					end
				end
				default: begin
					phase_next = ctrl_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= ctrl_idle;
			round <= '0;
			done  <= 1'b0;
		end else begin
			phase <= phase_next;
			round <= round_next;
			done  <= done_next;
		end
	end

endmodule

`default_nettype wire

//--- rtl/aes_core.sv
/*
 * AES-128 iterative encryption core
 * load captures key and plaintext, done rises twenty cycles later
 */
`timescale 1ns/1ps
`default_nettype none

module aes_core import aes_cipher_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       load,
	input  aes_block_t key,
	input  aes_block_t plaintext,
	output aes_block_t cyphertext,
	output logic       done
);

	aes_round_t round;
	logic       commit;
	logic       final_round;
	aes_block_t next_round_key;

	round_controller i_round_controller (
		.clk         (clk),
		.reset       (reset),
		.load        (load),
		.round       (round),
		.commit      (commit),
		.final_round (final_round),
		.done        (done)
	);

	key_expander i_key_expander (
		.clk            (clk),
		.reset          (reset),
		.load           (load),
		.key            (key),
		.round          (round),
		.commit         (commit),
		.next_round_key (next_round_key)
	);

	// cyphertext is the state register itself, final once done is high
	round_datapath i_round_datapath (
		.clk            (clk),
		.reset          (reset),
		.load           (load),
		.plaintext      (plaintext),
		.key            (key),
		.next_round_key (next_round_key),
		.commit         (commit),
		.final_round    (final_round),
		.state          (cyphertext)
	);

endmodule

`default_nettype wire

//--- bench/aes_vectors.svh
/*
 * AES-128 known-answer vectors
 * FIPS-197 appendices, all-zero block and SP 800-38A ECB block 1
 */
`ifndef aes_vectors_svh
`define aes_vectors_svh

// one row per vector across the three tables
// key, plaintext and expected cyphertext share the row index
localparam int num_vectors = 4;

localparam aes_block_t vec_key [0:num_vectors-1] = '{
	128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
	128'h00010203_04050607_08090a0b_0c0d0e0f,
	128'h00000000_00000000_00000000_00000000,
	128'h2b7e1516_28aed2a6_abf71588_09cf4f3c
};

localparam aes_block_t vec_plain [0:num_vectors-1] = '{
	128'h3243f6a8_885a308d_313198a2_e0370734,
	128'h00112233_44556677_8899aabb_ccddeeff,
	128'h00000000_00000000_00000000_00000000,
	128'h6bc1bee2_2e409f96_e93d7e11_7393172a
};

localparam aes_block_t vec_cipher [0:num_vectors-1] = '{
	128'h3925841d_02dc09fb_dc118597_196a0b32,
	128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a,
	128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e,
	128'h3ad77bb4_0d7a3660_a89ecaf3_2466ef97
};

`endif

//--- bench/aes_core_tb.sv
/*
 * AES-128 core testbench
 * known answers, idle gaps, restarts and back-to-back loads
 */
`timescale 1ns/1ps
`default_nettype none

module aes_core_tb import aes_cipher_pkg::*; ();

	`include "aes_vectors.svh"

	// 8 ns clock
	localparam int clk_half = 4;
	localparam int clk_period = 2 * clk_half;
	localparam int reset_cycles = 8;
	// idle gaps of 0 to 15 cycles
	localparam int gap_max = 16;
	// bound for the wait on done
	localparam int done_limit = aes_latency + 8;
	localparam int watchdog_cycles = num_vectors * 2 * (aes_latency + 16 + 20) + 100;

	logic       clk;
	logic       reset;
	logic       load;
	aes_block_t key;
	aes_block_t plaintext;
	aes_block_t cyphertext;
	logic       done;

	int seed = 32'h6a4c;

	aes_core i_dut (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.key        (key),
		.plaintext  (plaintext),
		.cyphertext (cyphertext),
		.done       (done)
	);

	always #(clk_half) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_block(input string name, input aes_block_t got,
		input aes_block_t expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t %s got %h expected %h", $time, name, got, expected);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t %s got %b expected %b", $time, name, got, expected);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("MISMATCH at %0t %s got %0d expected %0d", $time, name, got, expected);
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic aes_block_t random_block();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// call on a rising edge, returns on the load edge
	task automatic drive_load(input aes_block_t k, input aes_block_t p);
		load <= 1'b1;
		key <= k;
		plaintext <= p;
		@(posedge clk);
		load <= 1'b0;
		// key and plaintext matter only on the load edge
		key <= random_block();
		plaintext <= random_block();
	endtask

	// counts cycles from the load edge until done is seen high
	task automatic wait_for_done(output int cycles);
		cycles = 0;
		@(negedge clk);
		// load edge clears done
		check_flag("done", done, 1'b0);
		while (done !== 1'b1 && cycles < done_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("done did not rise within %0d cycles of the load", done_limit);
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int row;
		int next;
		int latency;
		int gap;
		int offset;
		clk = 1'b0;
		reset = 1'b1;
		load = 1'b0;
		key = '0;
		plaintext = '0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;

		// no load yet so done stays low
		repeat (4) begin
			@(negedge clk);
			check_flag("done", done, 1'b0);
		end
		@(posedge clk);

		// known answers with a random idle gap after each
		for (row = 0; row < num_vectors; row++) begin
			drive_load(vec_key[row], vec_plain[row]);
			wait_for_done(latency);
			check_count("load to done cycles", latency, aes_latency);
			check_block("cyphertext", cyphertext, vec_cipher[row]);
			gap = $unsigned($random(seed)) % gap_max;
			// result and done hold while idle
			repeat (gap) begin
				@(negedge clk);
				check_flag("done", done, 1'b1);
				check_block("cyphertext", cyphertext, vec_cipher[row]);
			end
			@(posedge clk);
		end

		// second load lands 1 to 19 cycles into a run
		for (row = 0; row < num_vectors; row++) begin
			next = (row + 1) % num_vectors;
			offset = 1 + ($unsigned($random(seed)) % (aes_latency - 1));
			drive_load(vec_key[row], vec_plain[row]);
			repeat (offset - 1) begin
				@(negedge clk);
				check_flag("done", done, 1'b0);
				@(posedge clk);
			end
			drive_load(vec_key[next], vec_plain[next]);
			wait_for_done(latency);
			check_count("restart to done cycles", latency, aes_latency);
			check_block("cyphertext", cyphertext, vec_cipher[next]);
			@(posedge clk);
		end

		// back-to-back loads on the edge after done is seen
		for (row = 0; row < num_vectors; row++) begin
			drive_load(vec_key[row], vec_plain[row]);
			wait_for_done(latency);
			check_count("back-to-back cycles", latency, aes_latency);
			check_block("cyphertext", cyphertext, vec_cipher[row]);
			@(posedge clk);
		end

		$display("Regression passed");
		$finish;
	end

	// bound on the whole run
	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout after %0d clock cycles without finishing the tests", watchdog_cycles);
		stop_run();
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
rtl/aes_field_pkg.sv
rtl/aes_cipher_pkg.sv
rtl/sbox.sv
rtl/mix_columns.sv
rtl/round_datapath.sv
rtl/key_expander.sv
rtl/round_controller.sv
rtl/aes_core.sv
bench/aes_core_tb.sv
